// ==== build.f ====
+incdir+include
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_retire.sv
design/rv_core.sv
dv/rv_core_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
TOP        = rv_core_tb
FILELIST   = build.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module rv_core_tb;

  import rv_pkg::*;

  // one value per mnemonic plus raw for words the core must not recognise
  typedef enum int {
    K_LUI, K_ADDI, K_SLTI, K_SLTIU, K_XORI,
    K_ORI, K_ANDI, K_SLLI, K_SRLI, K_SRAI,
    K_ADD, K_SUB, K_SLL, K_SLT, K_SLTU,
    K_XOR, K_SRL, K_SRA, K_OR, K_AND,
    K_RAW
  } kind_e;

  typedef struct {
    kind_e       kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [31:0] insn;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_we;
  } entry_t;

  logic          clk;
  logic          rst;
  insn_t         imem_data;
  word_t         imem_addr;
  word_t         trace_pc;
  insn_t         trace_insn;
  cycle_status_e trace_status;
  reg_idx_t      trace_rd;
  word_t         trace_data;
  logic          trace_we;

  entry_t      tbl[$];
  logic [31:0] model_regs [32];
  integer      seed;
  int          errors;
  int          cycle_count;
  int          cycle_limit;

  rv_core dut0 (
    .clk          (clk),
    .rst          (rst),
    .imem_data    (imem_data),
    .imem_addr    (imem_addr),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_rd     (trace_rd),
    .trace_data   (trace_data),
    .trace_we     (trace_we)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] encode(kind_e kind, logic [4:0] rd, logic [4:0] rs1,
                                         logic [4:0] rs2, logic [31:0] imm);
    logic [31:0] w;
    case (kind)
      K_LUI:   w = {imm[19:0], rd, `RV_OP_LUI};
      K_ADDI:  w = {imm[11:0], rs1, `RV_F3_ADD, rd, `RV_OP_REG_IMM};
      K_SLTI:  w = {imm[11:0], rs1, `RV_F3_SLT, rd, `RV_OP_REG_IMM};
      K_SLTIU: w = {imm[11:0], rs1, `RV_F3_SLTU, rd, `RV_OP_REG_IMM};
      K_XORI:  w = {imm[11:0], rs1, `RV_F3_XOR, rd, `RV_OP_REG_IMM};
      K_ORI:   w = {imm[11:0], rs1, `RV_F3_OR, rd, `RV_OP_REG_IMM};
      K_ANDI:  w = {imm[11:0], rs1, `RV_F3_AND, rd, `RV_OP_REG_IMM};
      K_SLLI:  w = {`RV_F7_BASE, imm[4:0], rs1, `RV_F3_SLL, rd, `RV_OP_REG_IMM};
      K_SRLI:  w = {`RV_F7_BASE, imm[4:0], rs1, `RV_F3_SR, rd, `RV_OP_REG_IMM};
      K_SRAI:  w = {`RV_F7_ALT, imm[4:0], rs1, `RV_F3_SR, rd, `RV_OP_REG_IMM};
      K_ADD:   w = {`RV_F7_BASE, rs2, rs1, `RV_F3_ADD, rd, `RV_OP_REG_REG};
      K_SUB:   w = {`RV_F7_ALT, rs2, rs1, `RV_F3_ADD, rd, `RV_OP_REG_REG};
      K_SLL:   w = {`RV_F7_BASE, rs2, rs1, `RV_F3_SLL, rd, `RV_OP_REG_REG};
      K_SLT:   w = {`RV_F7_BASE, rs2, rs1, `RV_F3_SLT, rd, `RV_OP_REG_REG};
      K_SLTU:  w = {`RV_F7_BASE, rs2, rs1, `RV_F3_SLTU, rd, `RV_OP_REG_REG};
      K_XOR:   w = {`RV_F7_BASE, rs2, rs1, `RV_F3_XOR, rd, `RV_OP_REG_REG};
      K_SRL:   w = {`RV_F7_BASE, rs2, rs1, `RV_F3_SR, rd, `RV_OP_REG_REG};
      K_SRA:   w = {`RV_F7_ALT, rs2, rs1, `RV_F3_SR, rd, `RV_OP_REG_REG};
      K_OR:    w = {`RV_F7_BASE, rs2, rs1, `RV_F3_OR, rd, `RV_OP_REG_REG};
      K_AND:   w = {`RV_F7_BASE, rs2, rs1, `RV_F3_AND, rd, `RV_OP_REG_REG};
      default: w = imm;
    endcase
    return w;
  endfunction

  // arithmetic right shift built from a logical shift and a fill mask
  function automatic logic [31:0] shift_right_arith(logic [31:0] a, logic [4:0] s);
    logic [31:0] fill;
    fill = a[31] ? ~(32'hffff_ffff >> s) : 32'h0;
    return (a >> s) | fill;
  endfunction

  function automatic logic [31:0] reference_result(entry_t e, logic [31:0] a, logic [31:0] b);
    logic [31:0] simm;
    simm = {{20{e.imm[11]}}, e.imm[11:0]};
    case (e.kind)
      K_LUI:   return {e.imm[19:0], 12'h000};
      K_ADDI:  return a + simm;
      K_SLTI:  return ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
      K_SLTIU: return (a < simm) ? 32'd1 : 32'd0;
      K_XORI:  return a ^ simm;
      K_ORI:   return a | simm;
      K_ANDI:  return a & simm;
      K_SLLI:  return a << e.imm[4:0];
      K_SRLI:  return a >> e.imm[4:0];
      K_SRAI:  return shift_right_arith(a, e.imm[4:0]);
      K_ADD:   return a + b;
      K_SUB:   return a - b;
      K_SLL:   return a << b[4:0];
      K_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      K_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      K_XOR:   return a ^ b;
      K_SRL:   return a >> b[4:0];
      K_SRA:   return shift_right_arith(a, b[4:0]);
      K_OR:    return a | b;
      K_AND:   return a & b;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] random_word();
    return $random(seed);
  endfunction

  task automatic add_insn(kind_e kind, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2,
                          logic [31:0] imm);
    entry_t e;
    e.kind     = kind;
    e.rd       = rd;
    e.rs1      = rs1;
    e.rs2      = rs2;
    e.imm      = imm;
    e.insn     = encode(kind, rd, rs1, rs2, imm);
    e.exp_rd   = '0;
    e.exp_data = '0;
    e.exp_we   = 1'b0;
    tbl.push_back(e);
  endtask

  task automatic add_raw_word(logic [31:0] word);
    add_insn(K_RAW, word[11:7], 5'd0, 5'd0, word);
  endtask

  task automatic build_table();
    // operands with x2 forced negative and x3 small positive
    add_insn(K_LUI, 5'd1, 5'd0, 5'd0, random_word());
    add_insn(K_ADDI, 5'd1, 5'd1, 5'd0, random_word());
    add_insn(K_LUI, 5'd2, 5'd0, 5'd0, 32'h0008_0000 | (random_word() & 32'h0007_ffff));
    add_insn(K_ADDI, 5'd2, 5'd2, 5'd0, random_word());
    add_insn(K_ADDI, 5'd3, 5'd0, 5'd0, random_word() & 32'h0000_07ff);
    // immediate forms with random immediates
    add_insn(K_SLTI, 5'd4, 5'd2, 5'd0, random_word());
    add_insn(K_SLTI, 5'd5, 5'd3, 5'd0, random_word());
    add_insn(K_SLTIU, 5'd6, 5'd2, 5'd0, random_word());
    add_insn(K_SLTIU, 5'd7, 5'd3, 5'd0, random_word());
    add_insn(K_XORI, 5'd8, 5'd1, 5'd0, random_word());
    add_insn(K_ORI, 5'd9, 5'd2, 5'd0, random_word());
    add_insn(K_ANDI, 5'd10, 5'd1, 5'd0, random_word());
    add_insn(K_SLLI, 5'd11, 5'd1, 5'd0, random_word());
    add_insn(K_SRLI, 5'd12, 5'd2, 5'd0, random_word());
    add_insn(K_SRAI, 5'd13, 5'd2, 5'd0, random_word());
    add_insn(K_SRAI, 5'd14, 5'd3, 5'd0, random_word());
    // signed and unsigned views of the same negative operand
    add_insn(K_SLTI, 5'd15, 5'd2, 5'd0, 32'd1);
    add_insn(K_SLTIU, 5'd16, 5'd2, 5'd0, 32'd1);
    add_insn(K_SLTIU, 5'd17, 5'd0, 5'd0, 32'h0000_0fff);
    // register forms
    add_insn(K_ADD, 5'd18, 5'd1, 5'd2, 32'h0);
    add_insn(K_SUB, 5'd19, 5'd0, 5'd1, 32'h0);
    add_insn(K_SUB, 5'd20, 5'd3, 5'd2, 32'h0);
    add_insn(K_SLL, 5'd21, 5'd1, 5'd11, 32'h0);
    add_insn(K_SLT, 5'd22, 5'd2, 5'd3, 32'h0);
    add_insn(K_SLTU, 5'd23, 5'd2, 5'd3, 32'h0);
    add_insn(K_XOR, 5'd24, 5'd1, 5'd2, 32'h0);
    add_insn(K_SRL, 5'd25, 5'd2, 5'd13, 32'h0);
    add_insn(K_SRA, 5'd26, 5'd2, 5'd1, 32'h0);
    add_insn(K_SRA, 5'd27, 5'd2, 5'd14, 32'h0);
    add_insn(K_OR, 5'd28, 5'd1, 5'd3, 32'h0);
    add_insn(K_AND, 5'd29, 5'd1, 5'd2, 32'h0);
    // dependency chain across MX, WX and the register file
    add_insn(K_ADDI, 5'd5, 5'd0, 5'd0, 32'd11);
    add_insn(K_ADDI, 5'd6, 5'd0, 5'd0, 32'd22);
    add_insn(K_ADD, 5'd7, 5'd5, 5'd6, 32'h0);
    add_insn(K_SUB, 5'd8, 5'd7, 5'd5, 32'h0);
    add_insn(K_ADD, 5'd9, 5'd7, 5'd8, 32'h0);
    // the younger of two producers of one register must win
    add_insn(K_ADDI, 5'd10, 5'd0, 5'd0, 32'd7);
    add_insn(K_ADDI, 5'd10, 5'd0, 5'd0, 32'd9);
    add_insn(K_ADD, 5'd11, 5'd10, 5'd0, 32'h0);
    add_insn(K_ADDI, 5'd12, 5'd0, 5'd0, 32'd1);
    add_insn(K_ADDI, 5'd12, 5'd0, 5'd0, 32'd2);
    add_insn(K_ADDI, 5'd13, 5'd0, 5'd0, 32'd3);
    add_insn(K_ADD, 5'd14, 5'd12, 5'd12, 32'h0);
    // x0 writes show on the trace but are never forwarded or stored
    add_insn(K_ADDI, 5'd0, 5'd0, 5'd0, 32'h0000_0055);
    add_insn(K_LUI, 5'd0, 5'd0, 5'd0, 32'h000a_bcde);
    add_insn(K_ADD, 5'd15, 5'd0, 5'd0, 32'h0);
    add_insn(K_ADD, 5'd16, 5'd0, 5'd15, 32'h0);
    add_insn(K_ADDI, 5'd16, 5'd0, 5'd0, 32'd33);
    add_insn(K_ADDI, 5'd17, 5'd0, 5'd0, 32'd44);
    add_insn(K_ADDI, 5'd31, 5'd0, 5'd0, 32'd66);
    // unrecognised words targeting live registers
    add_raw_word(32'hffff_ffff);
    add_raw_word(encode(K_SLLI, 5'd17, 5'd1, 5'd0, 32'd3) | 32'h4000_0000);
    add_raw_word(encode(K_ADD, 5'd16, 5'd1, 5'd2, 32'h0) | 32'h0200_0000);
    add_raw_word(32'h0000_0000);
    add_insn(K_ADD, 5'd18, 5'd16, 5'd0, 32'h0);
    add_insn(K_ADD, 5'd19, 5'd17, 5'd0, 32'h0);
    add_insn(K_ADD, 5'd20, 5'd31, 5'd0, 32'h0);
  endtask

  // walks the table in order and fills in the expected trace values
  task automatic run_model();
    entry_t      e;
    logic [31:0] result;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    foreach (tbl[i]) begin
      e = tbl[i];
      result = reference_result(e, model_regs[e.rs1], model_regs[e.rs2]);
      e.exp_rd = e.insn[11:7];
      if (e.kind == K_RAW) begin
        e.exp_we   = 1'b0;
        e.exp_data = 32'h0;
      end else begin
        e.exp_we   = 1'b1;
        e.exp_data = result;
        if (e.rd != 5'd0) begin
          model_regs[e.rd] = result;
        end
      end
      tbl[i] = e;
    end
  endtask

  // beyond the table the core sees ADDI x0, x0, 0
  function automatic logic [31:0] fetch_word(word_t addr);
    int unsigned index;
    index = addr >> 2;
    if (index < tbl.size()) begin
      return tbl[index].insn;
    end
    return encode(K_ADDI, 5'd0, 5'd0, 5'd0, 32'h0);
  endfunction

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic check_reset_trace();
    check_value("trace_status in reset", 32'(trace_status), 32'(CYCLE_RESET));
    check_value("trace_pc in reset", trace_pc, 32'h0);
    check_value("trace_insn in reset", trace_insn, 32'h0);
    check_value("trace_rd in reset", 32'(trace_rd), 32'h0);
    check_value("trace_data in reset", trace_data, 32'h0);
    check_value("trace_we in reset", 32'(trace_we), 32'h0);
  endtask

  task automatic check_entry(int idx);
    entry_t e;
    e = tbl[idx];
    check_value($sformatf("trace_pc entry %0d", idx), trace_pc, 32'(idx * 4));
    check_value($sformatf("trace_insn entry %0d", idx), trace_insn, e.insn);
    check_value($sformatf("trace_status entry %0d", idx), 32'(trace_status),
                32'(CYCLE_NO_STALL));
    check_value($sformatf("trace_rd entry %0d", idx), 32'(trace_rd), 32'(e.exp_rd));
    check_value($sformatf("trace_data entry %0d", idx), trace_data, e.exp_data);
    check_value($sformatf("trace_we entry %0d", idx), 32'(trace_we), 32'(e.exp_we));
    // fetch runs four words ahead of the trace
    check_value($sformatf("imem_addr entry %0d", idx), imem_addr, 32'((idx + 4) * 4));
  endtask

  // instruction memory answers the address on every falling edge
  initial begin
    imem_data = '0;
    forever begin
      @(negedge clk);
      imem_data = fetch_word(imem_addr);
    end
  end

  initial begin
    int reset_samples;
    rst = 1'b1;
    seed = 32'h3dcd_9b4d;
    errors = 0;
    build_table();
    run_model();
    cycle_limit = tbl.size() + 20;

    repeat (3) @(posedge clk);
    @(negedge clk);
    check_reset_trace();
    check_value("imem_addr in reset", imem_addr, 32'h0);
    rst = 1'b0;

    // bubbles drain for four edges before the first instruction retires
    reset_samples = 0;
    @(negedge clk);
    while (trace_status == CYCLE_RESET) begin
      check_reset_trace();
      reset_samples++;
      @(negedge clk);
    end
    check_value("reset cycles after release", 32'(reset_samples), 32'd3);

    for (int idx = 0; idx < tbl.size(); idx++) begin
      check_entry(idx);
      @(negedge clk);
    end

    $display("%0d entries checked, %0d errors", tbl.size(), errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the table did not retire in time", cycle_count);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::insn_t         imem_data,
  output rv_pkg::word_t         imem_addr,
  output rv_pkg::word_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status,
  output rv_pkg::reg_idx_t      trace_rd,
  output rv_pkg::word_t         trace_data,
  output logic                  trace_we
);

  import rv_pkg::*;

  // decode to execute
  word_t         d_pc;
  insn_t         d_insn;
  cycle_status_e d_status;
  reg_idx_t      d_rs1;
  reg_idx_t      d_rs2;
  reg_idx_t      d_rd;
  alu_op_e       d_op;
  logic          d_use_imm;
  word_t         d_imm_i;
  word_t         d_imm_u;

  // register file read data
  word_t rs1_val;
  word_t rs2_val;

  // execute to retire
  word_t         x_pc;
  insn_t         x_insn;
  cycle_status_e x_status;
  reg_idx_t      x_rd;
  word_t         x_data;
  logic          x_we;

  // bypass sources and the writeback request
  logic     m_we;
  reg_idx_t m_rd;
  word_t    m_data;
  logic     w_we;
  reg_idx_t w_rd;
  word_t    w_data;

  rv_fetch u_fetch (
    .clk (clk),
    .rst (rst),
    .pc  (imem_addr)
  );

  rv_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .pc_in    (imem_addr),
    .insn_in  (imem_data),
    .d_pc     (d_pc),
    .d_insn   (d_insn),
    .d_status (d_status),
    .rs1      (d_rs1),
    .rs2      (d_rs2),
    .rd       (d_rd),
    .op       (d_op),
    .use_imm  (d_use_imm),
    .imm_i    (d_imm_i),
    .imm_u    (d_imm_u)
  );

  // execute reads while writeback writes
  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (w_we),
    .wr_idx   (w_rd),
    .wr_data  (w_data),
    .rd_idx1  (d_rs1),
    .rd_idx2  (d_rs2),
    .rd_data1 (rs1_val),
    .rd_data2 (rs2_val)
  );

  rv_execute u_execute (
    .clk      (clk),
    .rst      (rst),
    .d_pc     (d_pc),
    .d_insn   (d_insn),
    .d_status (d_status),
    .rs1      (d_rs1),
    .rs2      (d_rs2),
    .rd       (d_rd),
    .op       (d_op),
    .use_imm  (d_use_imm),
    .imm_i    (d_imm_i),
    .imm_u    (d_imm_u),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .m_we     (m_we),
    .m_rd     (m_rd),
    .m_data   (m_data),
    .w_we     (w_we),
    .w_rd     (w_rd),
    .w_data   (w_data),
    .x_pc     (x_pc),
    .x_insn   (x_insn),
    .x_status (x_status),
    .x_rd     (x_rd),
    .x_data   (x_data),
    .x_we     (x_we)
  );

  rv_retire u_retire (
    .clk          (clk),
    .rst          (rst),
    .x_pc         (x_pc),
    .x_insn       (x_insn),
    .x_status     (x_status),
    .x_rd         (x_rd),
    .x_data       (x_data),
    .x_we         (x_we),
    .m_we         (m_we),
    .m_rd         (m_rd),
    .m_data       (m_data),
    .w_we         (w_we),
    .w_rd         (w_rd),
    .w_data       (w_data),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_rd     (trace_rd),
    .trace_data   (trace_data),
    .trace_we     (trace_we)
  );

endmodule

// ==== design/rv_retire.sv ====
`timescale 1ns/100ps

module rv_retire (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         x_pc,
  input  rv_pkg::insn_t         x_insn,
  input  rv_pkg::cycle_status_e x_status,
  input  rv_pkg::reg_idx_t      x_rd,
  input  rv_pkg::word_t         x_data,
  input  logic                  x_we,
  output logic                  m_we,
  output rv_pkg::reg_idx_t      m_rd,
  output rv_pkg::word_t         m_data,
  output logic                  w_we,
  output rv_pkg::reg_idx_t      w_rd,
  output rv_pkg::word_t         w_data,
  output rv_pkg::word_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status,
  output rv_pkg::reg_idx_t      trace_rd,
  output rv_pkg::word_t         trace_data,
  output logic                  trace_we
);

  import rv_pkg::*;

  word_t         m_pc;
  insn_t         m_insn;
  cycle_status_e m_status;
  word_t         w_pc;
  insn_t         w_insn;
  cycle_status_e w_status;

  // memory stage, values pass unchanged since there is no data memory
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= '0;
      m_status <= CYCLE_RESET;
      m_rd     <= '0;
      m_data   <= '0;
      m_we     <= 1'b0;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_status <= x_status;
      m_rd     <= x_rd;
      m_data   <= x_data;
      m_we     <= x_we;
    end
  end

  // writeback stage
  always_ff @(posedge clk) begin
    if (rst) begin
      w_pc     <= '0;
      w_insn   <= '0;
      w_status <= CYCLE_RESET;
      w_rd     <= '0;
      w_data   <= '0;
      w_we     <= 1'b0;
    end else begin
      w_pc     <= m_pc;
      w_insn   <= m_insn;
      w_status <= m_status;
      w_rd     <= m_rd;
      w_data   <= m_data;
      w_we     <= m_we;
    end
  end

  // trace shows the instruction whose write lands on the next edge
  assign trace_pc     = w_pc;
  assign trace_insn   = w_insn;
  assign trace_status = w_status;
  assign trace_rd     = w_rd;
  assign trace_data   = w_data;
  assign trace_we     = w_we;

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module rv_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         d_pc,
  input  rv_pkg::insn_t         d_insn,
  input  rv_pkg::cycle_status_e d_status,
  input  rv_pkg::reg_idx_t      rs1,
  input  rv_pkg::reg_idx_t      rs2,
  input  rv_pkg::reg_idx_t      rd,
  input  rv_pkg::alu_op_e       op,
  input  logic                  use_imm,
  input  rv_pkg::word_t         imm_i,
  input  rv_pkg::word_t         imm_u,
  input  rv_pkg::word_t         rs1_val,
  input  rv_pkg::word_t         rs2_val,
  input  logic                  m_we,
  input  rv_pkg::reg_idx_t      m_rd,
  input  rv_pkg::word_t         m_data,
  input  logic                  w_we,
  input  rv_pkg::reg_idx_t      w_rd,
  input  rv_pkg::word_t         w_data,
  output rv_pkg::word_t         x_pc,
  output rv_pkg::insn_t         x_insn,
  output rv_pkg::cycle_status_e x_status,
  output rv_pkg::reg_idx_t      x_rd,
  output rv_pkg::word_t         x_data,
  output logic                  x_we
);

  import rv_pkg::*;

  logic   m_fwd_ok;
  logic   w_fwd_ok;
  word_t  rs1_byp;
  word_t  rs2_byp;
  word_t  opa;
  word_t  opb;
  shamt_t shamt;

  // a stage only forwards when it really writes a register other than x0
  assign m_fwd_ok = m_we && (m_rd != '0);
  assign w_fwd_ok = w_we && (w_rd != '0);

  // MX first since memory holds the younger producer, then WX, then regfile
  assign rs1_byp = (m_fwd_ok && (m_rd == rs1)) ? m_data :
                   (w_fwd_ok && (w_rd == rs1)) ? w_data : rs1_val;
  assign rs2_byp = (m_fwd_ok && (m_rd == rs2)) ? m_data :
                   (w_fwd_ok && (w_rd == rs2)) ? w_data : rs2_val;

  assign opa = rs1_byp;
  assign opb = use_imm ? imm_i : rs2_byp;

  // for shift immediates this is imm_i[4:0]
  assign shamt = opb[4:0];

  always_comb begin
    case (op)
      // U immediate already sits in the upper 20 bits
      ALU_LUI:  x_data = imm_u;
      ALU_ADD:  x_data = opa + opb;
      ALU_SUB:  x_data = opa - opb;
      ALU_SLL:  x_data = opa << shamt;
      ALU_SLT:  x_data = word_t'($signed(opa) < $signed(opb));
      ALU_SLTU: x_data = word_t'(opa < opb);
      ALU_XOR:  x_data = opa ^ opb;
      ALU_SRL:  x_data = opa >> shamt;
      ALU_SRA:  x_data = $signed(opa) >>> shamt;
      ALU_OR:   x_data = opa | opb;
      ALU_AND:  x_data = opa & opb;
      default:  x_data = '0;
    endcase
  end

  // unrecognised instructions still travel down the pipe with their rd
  assign x_we     = (op != ALU_NONE);
  assign x_rd     = rd;
  assign x_pc     = d_pc;
  assign x_insn   = d_insn;
  assign x_status = d_status;

  // reset bubbles from decode must arrive as ALU_NONE and never write
  no_write_without_op: assert property (
    @(posedge clk) disable iff (rst)
    ((op == ALU_NONE) || (x_status != CYCLE_NO_STALL)) |-> !x_we
  );

endmodule

// ==== design/rv_regfile.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t wr_idx,
  input  rv_pkg::word_t    wr_data,
  input  rv_pkg::reg_idx_t rd_idx1,
  input  rv_pkg::reg_idx_t rd_idx2,
  output rv_pkg::word_t    rd_data1,
  output rv_pkg::word_t    rd_data2
);

  import rv_pkg::*;

  word_t regs [`RV_NUM_REGS];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // reads are combinational, x0 always reads as zero
  assign rd_data1 = (rd_idx1 == '0) ? '0 : regs[rd_idx1];
  assign rd_data2 = (rd_idx2 == '0) ? '0 : regs[rd_idx2];

  x0_stays_zero: assert property (
    @(posedge clk) disable iff (rst)
    regs[0] == '0
  );

endmodule

// ==== design/rv_decode.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module rv_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         pc_in,
  input  rv_pkg::insn_t         insn_in,
  output rv_pkg::word_t         d_pc,
  output rv_pkg::insn_t         d_insn,
  output rv_pkg::cycle_status_e d_status,
  output rv_pkg::reg_idx_t      rs1,
  output rv_pkg::reg_idx_t      rs2,
  output rv_pkg::reg_idx_t      rd,
  output rv_pkg::alu_op_e       op,
  output logic                  use_imm,
  output rv_pkg::word_t         imm_i,
  output rv_pkg::word_t         imm_u
);

  import rv_pkg::*;

  // decode stage register
  word_t         dec_pc;
  insn_t         dec_insn;
  cycle_status_e dec_status;

  // fields of the instruction in decode
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i_next;
  word_t      imm_u_next;
  alu_op_e    op_next;
  logic       use_imm_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_pc     <= '0;
      dec_insn   <= '0;
      dec_status <= CYCLE_RESET;
    end else begin
      dec_pc     <= pc_in;
      dec_insn   <= insn_in;
      dec_status <= CYCLE_NO_STALL;
    end
  end

  assign opcode = dec_insn[6:0];
  assign funct3 = dec_insn[14:12];
  assign funct7 = dec_insn[31:25];

  // I immediate is sign extended, U immediate sits in the top 20 bits
  assign imm_i_next = {{20{dec_insn[31]}}, dec_insn[31:20]};
  assign imm_u_next = {dec_insn[31:12], 12'b0};

  // anything not matched below stays ALU_NONE and writes nothing
  always_comb begin
    op_next      = ALU_NONE;
    use_imm_next = 1'b0;
    case (opcode)
      `RV_OP_LUI: begin
        op_next = ALU_LUI;
      end
      `RV_OP_REG_IMM: begin
        use_imm_next = 1'b1;
        case (funct3)
          `RV_F3_ADD:  op_next = ALU_ADD;
          `RV_F3_SLT:  op_next = ALU_SLT;
          `RV_F3_SLTU: op_next = ALU_SLTU;
          `RV_F3_XOR:  op_next = ALU_XOR;
          `RV_F3_OR:   op_next = ALU_OR;
          `RV_F3_AND:  op_next = ALU_AND;
          // shifts take shamt from imm[4:0], upper bits must be a valid funct7
          `RV_F3_SLL:  op_next = (funct7 == `RV_F7_BASE) ? ALU_SLL : ALU_NONE;
          `RV_F3_SR: begin
            if (funct7 == `RV_F7_BASE) begin
              op_next = ALU_SRL;
            end else if (funct7 == `RV_F7_ALT) begin
              op_next = ALU_SRA;
            end
          end
          default: op_next = ALU_NONE;
        endcase
      end
      `RV_OP_REG_REG: begin
        if (funct7 == `RV_F7_BASE) begin
          case (funct3)
            `RV_F3_ADD:  op_next = ALU_ADD;
            `RV_F3_SLL:  op_next = ALU_SLL;
            `RV_F3_SLT:  op_next = ALU_SLT;
            `RV_F3_SLTU: op_next = ALU_SLTU;
            `RV_F3_XOR:  op_next = ALU_XOR;
            `RV_F3_SR:   op_next = ALU_SRL;
            `RV_F3_OR:   op_next = ALU_OR;
            `RV_F3_AND:  op_next = ALU_AND;
            default:     op_next = ALU_NONE;
          endcase
        end else if (funct7 == `RV_F7_ALT) begin
          if (funct3 == `RV_F3_ADD) begin
            op_next = ALU_SUB;
          end else if (funct3 == `RV_F3_SR) begin
            op_next = ALU_SRA;
          end
        end
      end
      default: op_next = ALU_NONE;
    endcase
  end

  // execute stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= CYCLE_RESET;
      rs1      <= '0;
      rs2      <= '0;
      rd       <= '0;
      op       <= ALU_NONE;
      use_imm  <= 1'b0;
      imm_i    <= '0;
      imm_u    <= '0;
    end else begin
      d_pc     <= dec_pc;
      d_insn   <= dec_insn;
      d_status <= dec_status;
      rs1      <= dec_insn[19:15];
      rs2      <= dec_insn[24:20];
      rd       <= dec_insn[11:7];
      op       <= op_next;
      use_imm  <= use_imm_next;
      imm_i    <= imm_i_next;
      imm_u    <= imm_u_next;
    end
  end

endmodule

// ==== design/rv_fetch.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t pc
);

  // pc counter
  // starts at 0 and steps one word per cycle, nothing ever holds it
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc + `RV_PC_STEP;
    end
  end

  // instruction memory expects word addresses only
  pc_word_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  );

endmodule

// ==== design/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

  // register and data value
  typedef logic [`RV_XLEN-1:0] word_t;

  // raw instruction word
  typedef logic [31:0] insn_t;

  // register index, wide enough for every architectural register
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

  // shift amount for a 32-bit operand
  typedef logic [$clog2(`RV_XLEN)-1:0] shamt_t;

  // operation carried from decode to the ALU
  // immediate and register forms map onto the same value
  typedef enum logic [3:0] {
    ALU_NONE = 4'd0,
    ALU_LUI  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_SLL  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9,
    ALU_OR   = 4'd10,
    ALU_AND  = 4'd11
  } alu_op_e;

  // classification of the cycle seen at writeback
  // invalid should never show up once reset has drained
  typedef enum logic [1:0] {
    CYCLE_INVALID  = 2'd0,
    CYCLE_RESET    = 2'd1,
    CYCLE_NO_STALL = 2'd2
  } cycle_status_e;

endpackage

// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath and register file sizing
`define RV_XLEN      32
`define RV_NUM_REGS  32

// fetch advances one word per cycle
`define RV_PC_STEP   32'd4

// major opcodes kept by this core
`define RV_OP_LUI      7'b0110111
`define RV_OP_REG_IMM  7'b0010011
`define RV_OP_REG_REG  7'b0110011

// funct3 codes, shared by immediate and register forms
`define RV_F3_ADD   3'b000
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SR    3'b101
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

// funct7 codes
// alt selects SUB and the arithmetic right shifts
`define RV_F7_BASE  7'b0000000
`define RV_F7_ALT   7'b0100000

`endif
